//--- verilog/exec_config.svh
/*
   Width and field settings for the execute stage.
   Include in any file that sizes a datapath port or
   slices the opcode out of the instruction word.
*/
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Data and address width
// The carry-lookahead adder is fixed at 16 bits, so leave this alone
`define DATA_W 16

// Opcode field inside the instruction word
`define OPC_HI 15
`define OPC_LO 11

`endif

//--- verilog/execPkg.sv
/*
   Shared types for the execute stage.
   Holds the ALU operation codes and the branch opcodes decoded from the
   instruction's top five bits. Modules pull these in with a wildcard
   import in their header.
*/
package execPkg;

   // ALU operation select, set by decode
   typedef enum logic [3:0] {
      aluRol   = 4'd0,   // Rotate left by inB[3:0]
      aluSll   = 4'd1,   // Shift left logical
      aluRor   = 4'd2,   // Rotate right
      aluSrl   = 4'd3,   // Shift right logical
      aluAdd   = 4'd4,   // Add, subtract with invB and cIn
      aluOr    = 4'd5,
      aluXor   = 4'd6,
      aluAnd   = 4'd7,
      aluPassA = 4'd15   // A straight through, branches test this
   } aluOp;

   // Branch opcodes, instruction bits 15 down to 11
   // Anything else never sets the branch condition
   typedef enum logic [4:0] {
      opBeqz = 5'b01100,   // Taken when A is zero
      opBnez = 5'b01101,   // Taken when A is nonzero
      opBltz = 5'b01110,   // Taken when A is negative
      opBgez = 5'b01111    // Taken when A is zero or positive
   } brOpcode;

endpackage

//--- verilog/cla16.sv
/*
   16-bit carry-lookahead adder.
   Four 4-bit lookahead groups feed a second lookahead level for the group carries.
   c15 is the carry into the top bit, so callers can form signed overflow.
*/
module cla16 (
   input  logic [15:0] a,
   input  logic [15:0] b,
   input  logic        cIn,
   output logic [15:0] sum,
   output logic        cOut,
   output logic        c15
);

   logic [15:0] g, p;       // Bit generate and propagate
   logic [15:0] c;          // Carry into each bit
   logic [3:0]  gg, pg;     // Group generate and propagate
   logic [3:0]  gc;         // Carry into each group

   assign g = a & b;
   assign p = a ^ b;

   // Second level, carries into groups 1 to 3 and out of the top
   assign gc[0] = cIn;
   assign gc[1] = gg[0] | (pg[0] & cIn);
   assign gc[2] = gg[1] | (pg[1] & gg[0]) | (pg[1] & pg[0] & cIn);
   assign gc[3] = gg[2] | (pg[2] & gg[1]) | (pg[2] & pg[1] & gg[0]) |
                  (pg[2] & pg[1] & pg[0] & cIn);
   assign cOut  = gg[3] | (pg[3] & gc[3]);

   genvar k;
   generate
      for (k = 0; k < 4; k++) begin : grp
         logic [3:0] gs, ps;   // This group's slice
         assign gs = g[4*k +: 4];
         assign ps = p[4*k +: 4];
         assign gg[k] = gs[3] | (ps[3] & gs[2]) | (ps[3] & ps[2] & gs[1]) |
                        (ps[3] & ps[2] & ps[1] & gs[0]);
         assign pg[k] = &ps;
         // Carries inside the group, all from the group carry-in
         assign c[4*k]   = gc[k];
         assign c[4*k+1] = gs[0] | (ps[0] & gc[k]);
         assign c[4*k+2] = gs[1] | (ps[1] & gs[0]) | (ps[1] & ps[0] & gc[k]);
         assign c[4*k+3] = gs[2] | (ps[2] & gs[1]) | (ps[2] & ps[1] & gs[0]) |
                           (ps[2] & ps[1] & ps[0] & gc[k]);
      end
   endgenerate

   assign sum = p ^ c;
   assign c15 = c[15];

endmodule

//--- verilog/alu.sv
/*
   ALU for the execute stage.
   Either operand can be inverted before the operation, which with cIn = 1 gives subtract.
   Shift and rotate amounts come from the low four bits of B.
   ofl only means something for add. sign picks two's-complement or unsigned overflow.
*/
`include "exec_config.svh"

module alu import execPkg::*; (
   input  logic [`DATA_W-1:0] inA,
   input  logic [`DATA_W-1:0] inB,
   input  logic               cIn,
   input  logic               invA,
   input  logic               invB,
   input  logic               sign,
   input  aluOp               oper,
   output logic [`DATA_W-1:0] out,
   output logic               zero,
   output logic               ofl
);

   logic [`DATA_W-1:0]   opA, opB;         // Operands after optional inversion
   logic [`DATA_W-1:0]   sumOut;
   logic                 carry, c15;
   logic [3:0]           amt;              // Shift or rotate amount
   logic [2*`DATA_W-1:0] dblA;             // A beside itself, for rotates
   logic [2*`DATA_W-1:0] rolWide, rorWide;

   assign opA = invA ? ~inA : inA;
   assign opB = invB ? ~inB : inB;

   cla16 adder (
      .a   (opA),
      .b   (opB),
      .cIn (cIn),
      .sum (sumOut),
      .cOut(carry),
      .c15 (c15)
   );

   // Rotate unit. Bits pushed off one end wrap into the other half
   assign amt     = opB[3:0];
   assign dblA    = {opA, opA};
   assign rolWide = dblA << amt;
   assign rorWide = dblA >> amt;

   always_comb begin
      case (oper)
         aluRol:   out = rolWide[2*`DATA_W-1:`DATA_W];   // Upper half holds the wrap
         aluSll:   out = opA << amt;
         aluRor:   out = rorWide[`DATA_W-1:0];
         aluSrl:   out = opA >> amt;                     // Zero fill
         aluAdd:   out = sumOut;
         aluOr:    out = opA | opB;
         aluXor:   out = opA ^ opB;
         aluAnd:   out = opA & opB;
         aluPassA: out = opA;
         default:  out = '0;                             // Unused codes
      endcase
   end

   assign zero = ~|out;

   // Signed overflow when the carries into and out of the top bit differ
   always_comb begin
      if (oper == aluAdd)
         ofl = sign ? (c15 ^ carry) : carry;
      else
         ofl = 1'b0;
   end

endmodule

//--- verilog/execute.sv
/*
   Execute-stage datapath, purely combinational.
   Muxes the immediate into ALU input B, runs the ALU, adds the immediate
   to the incremented PC for the branch target, and resolves the branch.
   pcSrc tells fetch to take nextPc2 instead of its own next PC.
*/
`include "exec_config.svh"

module execute import execPkg::*; (
   input  logic [`DATA_W-1:0] instruction,
   input  logic [`DATA_W-1:0] nextPc1,        // PC + 2 from fetch
   input  logic [`DATA_W-1:0] read1Data,
   input  logic [`DATA_W-1:0] read2Data,
   input  logic [`DATA_W-1:0] extendOutput,   // Sign-extended immediate or offset
   input  logic               aluSrc,
   input  logic               aluCin,
   input  logic               invA,
   input  logic               invB,
   input  logic               aluSign,
   input  logic               branch,
   input  logic               jump,
   input  aluOp               aluOper,
   output logic [`DATA_W-1:0] nextPc2,        // Branch or jump target
   output logic [`DATA_W-1:0] aluOut,
   output logic               pcSrc,
   output logic               aluZero,
   output logic               aluOfl
);

   logic [`DATA_W-1:0] aluB;
   brOpcode            opc;
   logic               brCond;

   assign aluB = aluSrc ? extendOutput : read2Data;

   alu aluUnit (.inA(read1Data), .inB(aluB), .cIn(aluCin), .invA(invA), .invB(invB),
      .sign(aluSign), .oper(aluOper), .out(aluOut), .zero(aluZero), .ofl(aluOfl));

   // Offset is a byte offset already, no shift
   cla16 pcAdder (.a(nextPc1), .b(extendOutput), .cIn(1'b0), .sum(nextPc2), .cOut(), .c15());

   // Decode passes A through the ALU, so the test is on aluOut
   assign opc = brOpcode'(instruction[`OPC_HI:`OPC_LO]);

   always_comb begin
      case (opc)
         opBeqz:  brCond = ~|aluOut;
         opBnez:  brCond = |aluOut;
         opBltz:  brCond = aluOut[`DATA_W-1];    // Sign bit set
         opBgez:  brCond = ~aluOut[`DATA_W-1];
         default: brCond = 1'b0;                 // Not a branch opcode
      endcase
   end

   assign pcSrc = jump | (branch & brCond);   // Jumps ignore the condition

endmodule

//--- verilog/exMemReg.sv
/*
   EX/MEM pipeline register.
   Loads on every rising edge unless stall is high, and then every field holds,
   the valid bit too, so the item in flight waits.
   Synchronous active-low reset clears control and data alike.
*/
`include "exec_config.svh"

module exMemReg (
   input  logic               clk,
   input  logic               rstN,
   input  logic               stall,        // From hazard detection
   input  logic               inValid,
   input  logic [`DATA_W-1:0] nextPc2In,
   input  logic [`DATA_W-1:0] aluOutIn,
   input  logic               pcSrcIn,
   input  logic               zeroIn,
   input  logic               oflIn,
   output logic [`DATA_W-1:0] nextPc2,
   output logic [`DATA_W-1:0] aluOut,
   output logic               pcSrc,
   output logic               aluZero,
   output logic               aluOfl,
   output logic               outValid
);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         nextPc2  <= '0;
         aluOut   <= '0;
         pcSrc    <= 1'b0;
         aluZero  <= 1'b0;
         aluOfl   <= 1'b0;
         outValid <= 1'b0;
      end else if (!stall) begin
         nextPc2  <= nextPc2In;
         aluOut   <= aluOutIn;
         pcSrc    <= pcSrcIn;
         aluZero  <= zeroIn;
         aluOfl   <= oflIn;
         outValid <= inValid;     // Bubble when low, data still loads
      end
   end

endmodule

//--- verilog/exStage.sv
/*
   Execute stage with its EX/MEM register.
   Decode-side inputs go through the combinational datapath and land in the
   pipeline register one cycle later. stall freezes the register.
*/
`include "exec_config.svh"

module exStage import execPkg::*; (
   input  logic               clk,
   input  logic               rstN,
   input  logic [`DATA_W-1:0] instruction,
   input  logic [`DATA_W-1:0] nextPc1,
   input  logic [`DATA_W-1:0] read1Data,
   input  logic [`DATA_W-1:0] read2Data,
   input  logic [`DATA_W-1:0] extendOutput,
   input  logic               aluSrc,
   input  logic               aluCin,
   input  aluOp               aluOper,
   input  logic               invA,
   input  logic               invB,
   input  logic               aluSign,
   input  logic               branch,
   input  logic               jump,
   input  logic               inValid,
   input  logic               stall,
   output logic [`DATA_W-1:0] nextPc2,
   output logic [`DATA_W-1:0] aluOut,
   output logic               pcSrc,
   output logic               aluZero,
   output logic               aluOfl,
   output logic               outValid
);

   // Combinational results heading into the register
   logic [`DATA_W-1:0] exNextPc2, exAluOut;
   logic               exPcSrc, exZero, exOfl;

   execute exec (.instruction(instruction), .nextPc1(nextPc1), .read1Data(read1Data),
      .read2Data(read2Data), .extendOutput(extendOutput), .aluSrc(aluSrc), .aluCin(aluCin),
      .invA(invA), .invB(invB), .aluSign(aluSign), .branch(branch), .jump(jump),
      .aluOper(aluOper), .nextPc2(exNextPc2), .aluOut(exAluOut), .pcSrc(exPcSrc),
      .aluZero(exZero), .aluOfl(exOfl));

   exMemReg pipeReg (.clk(clk), .rstN(rstN), .stall(stall), .inValid(inValid),
      .nextPc2In(exNextPc2), .aluOutIn(exAluOut), .pcSrcIn(exPcSrc), .zeroIn(exZero),
      .oflIn(exOfl), .nextPc2(nextPc2), .aluOut(aluOut), .pcSrc(pcSrc),
      .aluZero(aluZero), .aluOfl(aluOfl), .outValid(outValid));

endmodule

//--- bench/exStage_checker.sv
/*
   Assertions on the exStage outputs, bound into every exStage instance.
   A stall must freeze the EX/MEM register, and reset must clear the valid
   and PC-select bits. assertFails gives the testbench a failure count.
*/
module exStageChecker (
   input logic        clk, rstN, stall,
   input logic [15:0] nextPc2, aluOut,
   input logic        pcSrc, aluZero, aluOfl, outValid
);

   int assertFails = 0;

   // Stall high at an edge, so nothing may change across it
   holdUnderStall: assert property (@(posedge clk) disable iff (!rstN)
         stall |=> $stable({nextPc2, aluOut, pcSrc, aluZero, aluOfl, outValid}))
      else begin
         assertFails++;
         $error("EX/MEM outputs changed across a stalled edge");
      end

   resetClears: assert property (@(posedge clk) !rstN |=> !outValid && !pcSrc)
      else begin
         assertFails++;
         $error("outValid or pcSrc set in the cycle after reset");
      end

endmodule

bind exStage exStageChecker chk (.*);

//--- bench/exStageMonitor.sv
/*
   Scoreboard for the execute-stage testbench.
   Queues the expected results of every accepted input (inValid high, stall low)
   and, when the register hands out a valid item on an unstalled edge, pops the
   oldest entry and compares the outputs. Counts come back out as ports.
*/
module exStageMonitor (
   input  logic         clk, rstN, stall, inValid,
   input  logic [127:0] caseName,                  // Case name as packed text
   input  logic [15:0]  expNextPc2, expAluOut,
   input  logic         expPcSrc, expZero, expOfl,
   input  logic [15:0]  nextPc2, aluOut,            // Registered DUT outputs
   input  logic         pcSrc, aluZero, aluOfl, outValid,
   output int           mismatches, strays, pending
);

   typedef struct packed {
      logic [127:0] name;
      logic [15:0]  nextPc2;
      logic [15:0]  aluOut;
      logic         pcSrc;
      logic         zero;
      logic         ofl;
   } expEntry;

   expEntry expQ[$];   // Oldest accepted case at the front
   expEntry head;

   task automatic compareField(input logic [127:0] name, input string field,
                               input logic [15:0] exp, input logic [15:0] act);
      if (act !== exp) begin
         $display("Mismatch %s %s expected %h actual %h", name, field, exp, act);
         mismatches++;
      end
   endtask

   always @(posedge clk) begin
      if (!rstN) begin
         expQ.delete();
      end else begin
         // Pop before push since the item on the outputs is always the older one
         if (outValid && !stall) begin
            if (expQ.size() == 0) begin
               $display("Valid output at %0t with no accepted case waiting for it", $time);
               strays++;
            end else begin
               head = expQ.pop_front();
               compareField(head.name, "nextPc2", head.nextPc2, nextPc2);
               compareField(head.name, "aluOut", head.aluOut, aluOut);
               compareField(head.name, "pcSrc", {15'b0, head.pcSrc}, {15'b0, pcSrc});
               compareField(head.name, "aluZero", {15'b0, head.zero}, {15'b0, aluZero});
               compareField(head.name, "aluOfl", {15'b0, head.ofl}, {15'b0, aluOfl});
            end
         end
         if (inValid && !stall)   // Bubbles never reach the queue
            expQ.push_back('{caseName, expNextPc2, expAluOut, expPcSrc, expZero, expOfl});
      end
      pending = expQ.size();
   end

endmodule

//--- bench/exStageTb.sv
/*
   Testbench for exStage.
   Reads bench/exStage_cases.txt, drives each case on the falling clock edge
   after 0 to 2 random stall cycles, and leaves the comparing to exStageMonitor.
   Ends with a second reset pulse over a loaded register.
   Run through run.sh from the project root.
*/
module exStageTb import execPkg::*; ();

   typedef struct packed {
      logic [127:0] name;
      logic [15:0]  instr, pc1, r1, r2, ext;
      logic         aluSrc, aluCin;
      logic [3:0]   oper;
      logic         invA, invB, sign, branch, jump, valid;
      logic [15:0]  expPc, expOut;
      logic         expPcSrc, expZero, expOfl;
   } caseRec;

   logic        clk, rstN, stall, inValid;
   logic        aluSrc, aluCin, invA, invB, aluSign, branch, jump;
   logic [15:0] instruction, nextPc1, read1Data, read2Data, extendOutput;
   aluOp        aluOper;
   logic [15:0] nextPc2, aluOut;
   logic        pcSrc, aluZero, aluOfl, outValid;
   caseRec      cur;        // Case on the inputs with its expected values
   caseRec      cases[$];
   int          mismatches, strays, pending, otherErrors, cycles, cycleLimit;

   exStage uut (.*);

   exStageMonitor mon (.clk, .rstN, .stall, .inValid, .caseName(cur.name),
      .expNextPc2(cur.expPc), .expAluOut(cur.expOut), .expPcSrc(cur.expPcSrc),
      .expZero(cur.expZero), .expOfl(cur.expOfl), .nextPc2, .aluOut, .pcSrc, .aluZero,
      .aluOfl, .outValid, .mismatches, .strays, .pending);

   always #10 clk = ~clk;   // 20-unit period

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycleLimit) begin
         $display("Timeout after %0d cycles, %0d accepted cases never reached the outputs",
                  cycles, pending);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic readCases();
      int fd, n;
      string line;
      logic [127:0] nm;
      logic [15:0] ins, pc1, r1, r2, ext, ePc, eOut;
      logic [3:0] op;
      logic aSrc, cin, iA, iB, sgn, br, jmp, vld, ePcSrc, eZero, eOfl;
      fd = $fopen("bench/exStage_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open the case file bench/exStage_cases.txt");
         otherErrors++;
         return;
      end
      while ($fgets(line, fd) > 0) begin
         if (line.len() < 2 || line.getc(0) == "#")   // Blank or column notes
            continue;
         n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     nm, ins, pc1, r1, r2, ext, aSrc, cin, op, iA, iB, sgn, br, jmp, vld,
                     ePc, eOut, ePcSrc, eZero, eOfl);
         if (n == 20) begin
            cases.push_back('{nm, ins, pc1, r1, r2, ext, aSrc, cin, op, iA, iB, sgn, br, jmp,
                              vld, ePc, eOut, ePcSrc, eZero, eOfl});
         end else begin
            $display("Malformed line in the case file: %s", line);
            otherErrors++;
         end
      end
      $fclose(fd);
   endtask

   task automatic driveCase(input caseRec c);
      cur          = c;
      instruction  = c.instr;
      nextPc1      = c.pc1;
      read1Data    = c.r1;
      read2Data    = c.r2;
      extendOutput = c.ext;
      aluOper      = aluOp'(c.oper);
      {aluSrc, aluCin, invA, invB, aluSign, branch, jump, inValid} =
         {c.aluSrc, c.aluCin, c.invA, c.invB, c.sign, c.branch, c.jump, c.valid};
      stall        = 1'b0;
   endtask

   task automatic finishRun();
      int total;
      total = mismatches + strays + otherErrors + uut.chk.assertFails;
      $display("Errors: %0d mismatches, %0d unexpected outputs, %0d assertion, %0d other",
               mismatches, strays, uut.chk.assertFails, otherErrors);
      if (total == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   endtask

   initial begin
      int gap;
      clk = 1'b0;
      rstN = 1'b0;
      otherErrors = 0;
      cycles = 0;
      driveCase('0);               // Every input known, inValid low
      void'($urandom(32'h47fd));   // One seed for the whole run
      readCases();
      if (cases.size() == 0) begin
         $display("No cases were read from the case file");
         otherErrors++;
      end
      cycleLimit = 4 * cases.size() + 40;
      repeat (4) @(negedge clk);
      rstN = 1'b1;
      foreach (cases[i]) begin
         gap = $urandom % 3;
         repeat (gap) begin
            @(negedge clk);
            driveCase(cases[i]);
            stall = 1'b1;          // New case waits on the inputs until stall drops
         end
         @(negedge clk);
         driveCase(cases[i]);
      end
      @(negedge clk);
      inValid = 1'b0;
      wait (pending == 0);         // Last accepted case popped by the monitor
      @(negedge clk);
      rstN = 1'b0;                 // Reset again with data left in the register
      @(negedge clk);
      rstN = 1'b1;
      @(negedge clk);
      finishRun();
   end

endmodule

//--- exStage.f
+incdir+verilog
verilog/execPkg.sv
verilog/cla16.sv
verilog/alu.sv
verilog/execute.sv
verilog/exMemReg.sv
verilog/exStage.sv
bench/exStage_checker.sv
bench/exStageMonitor.sv
bench/exStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the exStage testbench with Verilator from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exStageTb -f exStage.f -o exStageSim
./obj_dir/exStageSim +verilator+error+limit+1000 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
   exit 0
fi
exit 1

//--- bench/exStage_cases.txt
# name instr nextPc1 read1Data read2Data extendOutput aluSrc aluCin aluOper invA invB aluSign
#   branch jump inValid, then expected nextPc2 aluOut pcSrc aluZero aluOfl, all hex
add 0000 0100 1234 0f0f 0002 0 0 4 0 0 1 0 0 1 0102 2143 0 0 0
sub 0000 0100 5000 1234 0004 0 1 4 0 1 1 0 0 1 0104 3dcc 0 0 0
and 0000 0100 f0f0 3c3c 0006 0 0 7 0 0 0 0 0 1 0106 3030 0 0 0
or 0000 0100 f0f0 3c3c 0008 0 0 5 0 0 0 0 0 1 0108 fcfc 0 0 0
xor 0000 0100 f0f0 3c3c 000a 0 0 6 0 0 0 0 0 1 010a cccc 0 0 0
bubble1 0000 0100 1111 2222 0000 0 0 4 0 0 0 0 0 0 0000 0000 0 0 0
passA 0000 0100 beef 1234 000c 0 0 f 0 0 0 0 0 1 010c beef 0 0 0
immAdd 0000 0100 0010 ffff 0020 1 0 4 0 0 0 0 0 1 0120 0030 0 0 0
signedOfl 0000 0100 7fff 0001 0000 0 0 4 0 0 1 0 0 1 0100 8000 0 0 1
unsignedCarry 0000 0100 ffff 0001 0000 0 0 4 0 0 0 0 0 1 0100 0000 0 1 1
rol0 0000 0200 8421 0000 0000 0 0 0 0 0 0 0 0 1 0200 8421 0 0 0
rol1 0000 0200 8421 0001 0000 0 0 0 0 0 0 0 0 1 0200 0843 0 0 0
rol15 0000 0200 8421 000f 0000 0 0 0 0 0 0 0 0 1 0200 c210 0 0 0
sll1 0000 0200 8421 0001 0000 0 0 1 0 0 0 0 0 1 0200 0842 0 0 0
srl15 0000 0200 8421 000f 0000 0 0 3 0 0 0 0 0 1 0200 0001 0 0 0
ror15 0000 0200 8421 000f 0000 0 0 2 0 0 0 0 0 1 0200 0843 0 0 0
beqzTaken 6000 0300 0000 0000 0010 0 0 f 0 0 0 1 0 1 0310 0000 1 1 0
beqzNot 6000 0300 0005 0000 0010 0 0 f 0 0 0 1 0 1 0310 0005 0 0 0
bubble2 6800 0300 0005 0000 0010 0 0 f 0 0 0 1 0 0 0000 0000 0 0 0
bnezTaken 6800 0300 0005 0000 0010 0 0 f 0 0 0 1 0 1 0310 0005 1 0 0
bnezNot 6800 0300 0000 0000 0010 0 0 f 0 0 0 1 0 1 0310 0000 0 1 0
bltzTaken 7000 0300 8000 0000 0010 0 0 f 0 0 0 1 0 1 0310 8000 1 0 0
bltzNot 7000 0300 0001 0000 0010 0 0 f 0 0 0 1 0 1 0310 0001 0 0 0
bgezTaken 7800 0300 0000 0000 0010 0 0 f 0 0 0 1 0 1 0310 0000 1 1 0
bgezNot 7800 0300 ffff 0000 0010 0 0 f 0 0 0 1 0 1 0310 ffff 0 0 0
jump 6000 0400 0005 0000 fff0 0 0 f 0 0 0 0 1 1 03f0 0005 1 0 0
